// ==== rtl/board_io_pkg.sv ====
package board_io_pkg;

    localparam int bus_width       = 32;
    localparam int switch_width    = 10;
    localparam int button_width    = 4;
    localparam int input_width     = switch_width + button_width;
    localparam int red_led_width   = 18;
    localparam int green_led_width = 9;
    localparam int nibble_width    = 4;
    localparam int segment_width   = 7;

    // stable synchronized cycles before a new level is accepted
    localparam int debounce_cycles      = 8;
    localparam int debounce_count_width = $clog2(debounce_cycles);

    localparam logic [bus_width-1:0] addr_switches   = 32'h0000_0000;
    localparam logic [bus_width-1:0] addr_buttons    = 32'h0000_0004;
    localparam logic [bus_width-1:0] addr_red_leds   = 32'h0000_0008;
    localparam logic [bus_width-1:0] addr_green_leds = 32'h0000_000c;

    typedef struct packed {
        logic [switch_width-1:0] switches;
        logic [button_width-1:0] buttons;    // 1 = pressed
    } io_inputs_t;

    typedef struct packed {
        logic [bus_width-1:0] addr;
        logic [bus_width-1:0] wdata;
        logic                 write;
    } bus_req_t;

    typedef struct packed {
        logic [red_led_width-1:0]   red_leds;
        logic [green_led_width-1:0] green_leds;
    } io_outputs_t;

    typedef struct packed {
        logic [nibble_width-1:0] hex5;
        logic [nibble_width-1:0] hex4;
        logic [nibble_width-1:0] hex3;
        logic [nibble_width-1:0] hex2;
        logic [nibble_width-1:0] hex1;
        logic [nibble_width-1:0] hex0;
    } hex_digits_t;

    // active-low segments, segment a in bit 0
    typedef struct packed {
        logic [segment_width-1:0] hex5;
        logic [segment_width-1:0] hex4;
        logic [segment_width-1:0] hex3;
        logic [segment_width-1:0] hex2;
        logic [segment_width-1:0] hex1;
        logic [segment_width-1:0] hex0;
    } hex_display_t;

    localparam hex_display_t hex_display_zero = {6{7'b100_0000}};    // "0" on every digit

endpackage

// ==== rtl/switch_debouncer.sv ====
module switch_debouncer (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic [board_io_pkg::switch_width-1:0] sw,
    input  logic [board_io_pkg::button_width-1:0] key,
    output board_io_pkg::io_inputs_t              inputs
);

    import board_io_pkg::*;

    logic [input_width-1:0]          raw;
    logic [input_width-1:0]          sync_meta;
    logic [input_width-1:0]          sync_q;
    logic [input_width-1:0]          stable;
    logic [debounce_count_width-1:0] count [input_width];

    assign raw = {sw, ~key};    // keys are active low on the board

    // two-flop synchronizer
    always_ff @(posedge clk) begin
        if (reset) begin
            sync_meta <= '0;
            sync_q    <= '0;
        end else begin
            sync_meta <= raw;
            sync_q    <= sync_meta;
        end
    end

    // A bit changes only after it has differed from the accepted level
    // for debounce_cycles consecutive synchronized samples.
    always_ff @(posedge clk) begin
        if (reset) begin
            stable <= '0;    // released
            for (int i = 0; i < input_width; i++) begin
                count[i] <= '0;
            end
        end else begin
            for (int i = 0; i < input_width; i++) begin
                if (sync_q[i] == stable[i]) begin
                    count[i] <= '0;    // glitch over, start again
                end else if (count[i] == debounce_count_width'(debounce_cycles - 1)) begin
                    stable[i] <= sync_q[i];
                    count[i]  <= '0;
                end else begin
                    count[i] <= count[i] + 1'b1;
                end
            end
        end
    end

    assign inputs = io_inputs_t'(stable);

endmodule

// ==== rtl/io_register_bank.sv ====
module io_register_bank (
    input  logic                               clk,
    input  logic                               reset,
    input  board_io_pkg::io_inputs_t           inputs,
    input  board_io_pkg::bus_req_t             bus_req,
    output logic [board_io_pkg::bus_width-1:0] rdata,
    output board_io_pkg::io_outputs_t          leds,
    output board_io_pkg::hex_digits_t          digits
);

    import board_io_pkg::*;

    logic                    sel_switches;
    logic                    sel_buttons;
    logic                    sel_red;
    logic                    sel_green;
    logic                    write_red;
    logic                    write_green;
    logic [bus_width-1:0]    read_word;
    logic [nibble_width-1:0] addr_top;

    // full address decode
    assign sel_switches = (bus_req.addr == addr_switches);
    assign sel_buttons  = (bus_req.addr == addr_buttons);
    assign sel_red      = (bus_req.addr == addr_red_leds);
    assign sel_green    = (bus_req.addr == addr_green_leds);

    // switches and buttons are read only
    assign write_red   = bus_req.write && sel_red;
    assign write_green = bus_req.write && sel_green;

    always_comb begin
        read_word = '0;    // unmapped reads
        if (sel_switches) begin
            read_word = bus_width'(inputs.switches);
        end else if (sel_buttons) begin
            read_word = bus_width'(inputs.buttons);
        end else if (sel_red) begin
            read_word = bus_width'(leds.red_leds);
        end else if (sel_green) begin
            read_word = bus_width'(leds.green_leds);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            leds     <= '0;
            addr_top <= '0;
            rdata    <= '0;
        end else begin
            addr_top <= bus_req.addr[bus_width-1 -: nibble_width];    // shown on hex5
            rdata    <= read_word;
            if (write_red) begin
                leds.red_leds <= bus_req.wdata[red_led_width-1:0];
            end
            if (write_green) begin
                leds.green_leds <= bus_req.wdata[green_led_width-1:0];
            end
        end
    end

    // same digit wiring as the board top
    assign digits.hex0 = leds.red_leds[3:0];
    assign digits.hex1 = leds.red_leds[7:4];
    assign digits.hex2 = leds.red_leds[11:8];
    assign digits.hex3 = leds.red_leds[15:12];
    assign digits.hex4 = {2'b00, leds.red_leds[red_led_width-1:16]};
    assign digits.hex5 = addr_top;

endmodule

// ==== rtl/seven_segment_driver.sv ====
module seven_segment_driver (
    input  logic                       clk,
    input  logic                       reset,
    input  board_io_pkg::hex_digits_t  digits,
    output board_io_pkg::hex_display_t hex
);

    import board_io_pkg::*;

    hex_display_t next_hex;

    // active low, bit order gfedcba
    function automatic logic [segment_width-1:0] hex_to_segments(
        input logic [nibble_width-1:0] nibble
    );
        logic [segment_width-1:0] seg;
        case (nibble)
            4'h0:    seg = 7'b100_0000;
            4'h1:    seg = 7'b111_1001;
            4'h2:    seg = 7'b010_0100;
            4'h3:    seg = 7'b011_0000;
            4'h4:    seg = 7'b001_1001;
            4'h5:    seg = 7'b001_0010;
            4'h6:    seg = 7'b000_0010;
            4'h7:    seg = 7'b111_1000;
            4'h8:    seg = 7'b000_0000;
            4'h9:    seg = 7'b001_0000;
            4'ha:    seg = 7'b000_1000;
            4'hb:    seg = 7'b000_0011;    // lower case b
            4'hc:    seg = 7'b100_0110;
            4'hd:    seg = 7'b010_0001;    // lower case d
            4'he:    seg = 7'b000_0110;
            default: seg = 7'b000_1110;    // F
        endcase
        return seg;
    endfunction

    always_comb begin
        next_hex.hex0 = hex_to_segments(digits.hex0);
        next_hex.hex1 = hex_to_segments(digits.hex1);
        next_hex.hex2 = hex_to_segments(digits.hex2);
        next_hex.hex3 = hex_to_segments(digits.hex3);
        next_hex.hex4 = hex_to_segments(digits.hex4);
        next_hex.hex5 = hex_to_segments(digits.hex5);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            hex <= hex_display_zero;
        end else begin
            hex <= next_hex;
        end
    end

endmodule

// ==== rtl/board_io_top.sv ====
module board_io_top (
    input  logic                                     clk,
    input  logic                                     reset,
    input  logic [board_io_pkg::switch_width-1:0]    sw,
    input  logic [board_io_pkg::button_width-1:0]    key,
    input  board_io_pkg::bus_req_t                   bus_req,
    output logic [board_io_pkg::bus_width-1:0]       rdata,
    output logic [board_io_pkg::green_led_width-1:0] ledr,
    output logic [board_io_pkg::red_led_width-1:0]   red_leds,
    output board_io_pkg::hex_display_t               hex
);

    import board_io_pkg::*;

    io_inputs_t  inputs;
    io_outputs_t leds;
    hex_digits_t digits;

    switch_debouncer u_debouncer (
        .clk    ( clk    ),
        .reset  ( reset  ),
        .sw     ( sw     ),
        .key    ( key    ),
        .inputs ( inputs )
    );

    io_register_bank u_registers (
        .clk     ( clk     ),
        .reset   ( reset   ),
        .inputs  ( inputs  ),
        .bus_req ( bus_req ),
        .rdata   ( rdata   ),
        .leds    ( leds    ),
        .digits  ( digits  )
    );

    seven_segment_driver u_display (
        .clk    ( clk    ),
        .reset  ( reset  ),
        .digits ( digits ),
        .hex    ( hex    )
    );

    assign ledr     = leds.green_leds;
    assign red_leds = leds.red_leds;

endmodule

// ==== testbench/board_io_chk.sv ====
module board_io_chk (
    input  logic                               clk,
    input  logic                               reset,
    input  board_io_pkg::bus_req_t             bus_req,
    input  logic [board_io_pkg::bus_width-1:0] rdata,
    input  board_io_pkg::io_outputs_t          leds
);

    timeunit 1ns;
    timeprecision 100ps;

    import board_io_pkg::*;

    int   assert_failures = 0;    // read by the testbench
    logic read_only_write;

    assign read_only_write = bus_req.write
                          && (bus_req.addr == addr_switches || bus_req.addr == addr_buttons);

    zero_after_reset: assert property (@(posedge clk) reset |=> (leds == '0 && rdata == '0))
        else begin
            $error("register bank outputs are not zero one cycle after reset");
            assert_failures++;
        end

    read_only_ignored: assert property (@(posedge clk) disable iff (reset)
        read_only_write |=> $stable(leds))
        else begin
            $error("write to a read-only address changed the LED registers");
            assert_failures++;
        end

endmodule

// ==== testbench/board_io_tb.sv ====
module board_io_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import board_io_pkg::*;

    localparam int clock_period    = 4;
    localparam int reset_cycles    = 16;
    localparam int drive_delay     = 1;
    localparam int stim_depth      = 256;
    localparam int watchdog_cycles = 5000;

    // record opcodes of the stimulus file
    localparam int op_end   = 0;
    localparam int op_write = 1;
    localparam int op_read  = 2;
    localparam int op_set   = 3;
    localparam int op_wait  = 4;
    localparam int op_leds  = 5;
    localparam int op_hex   = 6;
    localparam int op_poll  = 7;

    // active low, segment a in bit 0
    localparam logic [segment_width-1:0] segment_table [16] = '{
        7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
        7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0e
    };

    logic                       clk;
    logic                       reset;
    logic [switch_width-1:0]    sw;
    logic [button_width-1:0]    key;
    bus_req_t                   bus_req;
    logic [bus_width-1:0]       rdata;
    logic [green_led_width-1:0] ledr;
    logic [red_led_width-1:0]   red_leds;
    hex_display_t               hex;
    logic [31:0]                stim_mem [stim_depth];

    board_io_top u_dut (
        .clk      ( clk      ),
        .reset    ( reset    ),
        .sw       ( sw       ),
        .key      ( key      ),
        .bus_req  ( bus_req  ),
        .rdata    ( rdata    ),
        .ledr     ( ledr     ),
        .red_leds ( red_leds ),
        .hex      ( hex      )
    );

    bind io_register_bank board_io_chk u_chk (
        .clk     ( clk     ),
        .reset   ( reset   ),
        .bus_req ( bus_req ),
        .rdata   ( rdata   ),
        .leds    ( leds    )
    );

    task automatic stop_with_failure();
        $display("Simulation failed");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic check_word(input string name, input logic [bus_width-1:0] expected,
                              input logic [bus_width-1:0] actual);
        if (actual !== expected) begin
            $display("ERROR at %0t: %s expected %h, actual %h", $time, name, expected, actual);
            stop_with_failure();
        end
    endtask

    task automatic check_leds(input io_outputs_t expected, input io_outputs_t actual);
        if (actual !== expected) begin
            $display("ERROR at %0t: leds expected %h, actual %h", $time, expected, actual);
            stop_with_failure();
        end
    endtask

    task automatic check_display(input hex_display_t expected, input hex_display_t actual);
        if (actual !== expected) begin
            $display("ERROR at %0t: hex expected %h, actual %h", $time, expected, actual);
            stop_with_failure();
        end
    endtask

    function automatic hex_display_t expected_display(input logic [23:0] nibbles);
        hex_display_t d;
        d.hex0 = segment_table[nibbles[3:0]];
        d.hex1 = segment_table[nibbles[7:4]];
        d.hex2 = segment_table[nibbles[11:8]];
        d.hex3 = segment_table[nibbles[15:12]];
        d.hex4 = segment_table[nibbles[19:16]];
        d.hex5 = segment_table[nibbles[23:20]];
        return d;
    endfunction

    // every bus task starts and ends just after a rising edge
    task automatic bus_write(input logic [bus_width-1:0] addr, input logic [bus_width-1:0] data);
        bus_req.addr  = addr;
        bus_req.wdata = data;
        bus_req.write = 1'b1;
        @(posedge clk);
        #drive_delay;
        bus_req.write = 1'b0;    // addr stays, hex5 keeps it
    endtask

    task automatic bus_read(input logic [bus_width-1:0] addr, output logic [bus_width-1:0] word);
        bus_req.addr  = addr;
        bus_req.write = 1'b0;
        @(posedge clk);
        #drive_delay;
        word = rdata;
    endtask

    task automatic wait_cycles(input int cycles);
        repeat (cycles) @(posedge clk);
        #drive_delay;
    endtask

    task automatic poll_read(input logic [bus_width-1:0] addr, input int limit,
                             input logic [bus_width-1:0] expected);
        int                   reads;
        logic [bus_width-1:0] word;
        reads = 1;
        bus_read(addr, word);
        while (word !== expected) begin
            if (reads >= limit) begin
                $display("address %h did not read %h within %0d reads", addr, expected, limit);
                stop_with_failure();
            end else begin
                reads++;
                bus_read(addr, word);
            end
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #(clock_period / 2) clk = ~clk;
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("watchdog expired before the stimulus file was finished");
        stop_with_failure();
    end

    always @(negedge clk) begin
        if (u_dut.u_registers.u_chk.assert_failures != 0) begin
            $display("a bound assertion on the register bank failed");
            stop_with_failure();
        end
    end

    initial begin : run_stimulus
        int                   index;
        bit                   done;
        logic [31:0]          op;
        logic [31:0]          a;
        logic [31:0]          b;
        logic [31:0]          c;
        logic [bus_width-1:0] word;
        io_outputs_t          exp_leds;

        sw      = '0;
        key     = '1;    // released
        bus_req = '0;
        reset   = 1'b1;
        $readmemh("testbench/board_io_stim.txt", stim_mem);
        repeat (reset_cycles) @(posedge clk);
        #drive_delay;
        reset = 1'b0;

        index = 0;
        done  = 1'b0;
        while (!done) begin
            if (index + 4 > stim_depth) begin
                $display("stimulus file has no end record");
                stop_with_failure();
            end
            op = stim_mem[index];
            a  = stim_mem[index + 1];
            b  = stim_mem[index + 2];
            c  = stim_mem[index + 3];
            index += 4;
            case (op)
                op_end:   done = 1'b1;
                op_write: bus_write(a, b);
                op_read: begin
                    bus_read(a, word);
                    check_word("rdata", c, word);
                end
                op_set: begin
                    sw  = b[switch_width-1:0];
                    key = b[switch_width +: button_width];
                end
                op_wait:  wait_cycles(b);
                op_leds: begin
                    exp_leds.red_leds   = a[red_led_width-1:0];
                    exp_leds.green_leds = b[green_led_width-1:0];
                    check_leds(exp_leds, {red_leds, ledr});
                end
                op_hex:   check_display(expected_display(a[23:0]), hex);
                op_poll:  poll_read(a, b, c);
                default: begin
                    $display("unknown operation %h in stimulus record %0d", op, index / 4);
                    stop_with_failure();
                end
            endcase
        end

        if (u_dut.u_registers.u_chk.assert_failures == 0) begin
            $display("Simulation passed");
            $finish;
        end else begin
            $display("a bound assertion on the register bank failed");
            stop_with_failure();
        end
    end

endmodule

// ==== testbench/board_io_stim.txt ====
// columns: op a b c (hex). 1 write a=addr b=data, 2 read a=addr c=expected, 3 set b={key,sw}
// 4 wait b=cycles, 5 leds a=red b=green, 6 hex a=nibbles hex5..hex0, 7 poll a=addr b=limit c=expected
5 00000000 00000000 00000000
6 00000000 00000000 00000000
2 00000004 00000000 00000000
2 00000000 00000000 00000000
2 00000008 00000000 00000000
// led writes, wide data truncated
1 00000008 fff3abcd 00000000
5 0003abcd 00000000 00000000
4 00000000 00000001 00000000
6 0003abcd 00000000 00000000
1 0000000c ffffff5a 00000000
5 0003abcd 0000015a 00000000
// readback and unmapped addresses
2 00000008 00000000 0003abcd
2 0000000c 00000000 0000015a
2 00000010 00000000 00000000
2 80000008 00000000 00000000
// read-only addresses ignore writes
1 00000000 ffffffff 00000000
1 00000004 ffffffff 00000000
5 0003abcd 0000015a 00000000
2 00000000 00000000 00000000
// address digit after a write and after a read
1 90000000 12345678 00000000
4 00000000 00000001 00000000
6 0093abcd 00000000 00000000
2 c0000000 00000000 00000000
4 00000000 00000001 00000000
6 00c3abcd 00000000 00000000
5 0003abcd 0000015a 00000000
1 00000008 0002f0e1 00000000
4 00000000 00000001 00000000
6 0002f0e1 00000000 00000000
2 00000008 00000000 0002f0e1
// stable switch change, then a 6 cycle glitch
3 00000000 00003ea5 00000000
7 00000000 00000020 000002a5
3 00000000 00003d5a 00000000
4 00000000 00000006 00000000
3 00000000 00003ea5 00000000
4 00000000 00000014 00000000
2 00000000 00000000 000002a5
// key 0 pressed, active low
3 00000000 00003aa5 00000000
7 00000004 00000020 00000001
3 00000000 00003ea5 00000000
7 00000004 00000020 00000000
0 00000000 00000000 00000000

// ==== build.f ====
rtl/board_io_pkg.sv
rtl/switch_debouncer.sv
rtl/io_register_bank.sv
rtl/seven_segment_driver.sv
rtl/board_io_top.sv
testbench/board_io_chk.sv
testbench/board_io_tb.sv

// ==== Bender.yml ====
package:
  name: board_io

sources:
  - files:
      - rtl/board_io_pkg.sv
      - rtl/switch_debouncer.sv
      - rtl/io_register_bank.sv
      - rtl/seven_segment_driver.sv
      - rtl/board_io_top.sv
  - target: test
    files:
      - testbench/board_io_chk.sv
      - testbench/board_io_tb.sv

# simulation top: board_io_tb
# design top: board_io_top
# the testbench reads testbench/board_io_stim.txt from the project root
